//--- build.f
+incdir+hdl
hdl/pipeline_pkg.sv
hdl/issue_pkg.sv
hdl/data_hazard_detector.sv
hdl/interrupt_snapshot.sv
hdl/issue_controller.sv
hdl/hazard_unit.sv
dv/tb_clock_gen.sv
dv/hazard_unit_tb.sv

//--- dv/hazard_unit_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "hazard_params.svh"

module hazard_unit_tb;

    import pipeline_pkg::*;
    import issue_pkg::*;

    localparam real CLK_PERIOD   = 100.0;
    localparam int  RESET_CYCLES = 16;
    localparam int  HAZ_ITERS    = 200;                 // random dependency sets
    localparam int  TOTAL_CYCLES = RESET_CYCLES + 1 + 2 * HAZ_ITERS +
                                   (`HAZD_DRAIN_LEN + 4) + (`HAZD_DRAIN_LEN + 5) + 5;

    localparam stage_ctl_t CTL_NORMAL = '{NORMAL, NORMAL, NORMAL, NORMAL, NORMAL};
    localparam stage_ctl_t CTL_DRAIN  = '{NO_OP, NORMAL, NORMAL, NORMAL, NORMAL};
    localparam stage_ctl_t CTL_FROZEN = '{NO_OP, NO_OP, NO_OP, NO_OP, NO_OP};

    logic          clk;
    logic          rst_n;
    logic          branch_instruction;
    logic          store_instruction;
    stage_status_t stage_status;
    reg_idx_t      reg_idx;
    logic          cpu_pause;
    logic          input_enable;
    logic          input_complete;
    logic          uart_write_enable;
    logic          uart_complete;
    stage_ctl_t    stage_ctl;
    issue_e        issue_type;
    logic          uart_disable;
    logic          ignore_pause;
    logic          pc_reset;
    logic          ignore_no_op;

    integer     seed;
    string      cur_test;
    int         err_cnt;
    int         test_errs;                              // mismatches in the running test
    int         check_cnt;
    int         test_cnt;
    bit         check_on;
    issue_e     exp_issue;
    stage_ctl_t exp_ctl;
    logic [3:0] exp_flags;                              // uart_disable, ignore_pause, pc_reset, ignore_no_op

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clk_gen (.clk(clk));

    hazard_unit hazard_unit_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .branch_instruction (branch_instruction),
        .store_instruction  (store_instruction),
        .stage_status       (stage_status),
        .reg_idx            (reg_idx),
        .cpu_pause          (cpu_pause),
        .input_enable       (input_enable),
        .input_complete     (input_complete),
        .uart_write_enable  (uart_write_enable),
        .uart_complete      (uart_complete),
        .stage_ctl          (stage_ctl),
        .issue_type         (issue_type),
        .uart_disable       (uart_disable),
        .ignore_pause       (ignore_pause),
        .pc_reset           (pc_reset),
        .ignore_no_op       (ignore_no_op)
    );

    function automatic stage_ctl_t make_ctl(input hazd_ctl_e c_if, input hazd_ctl_e c_id,
                                            input hazd_ctl_e c_ex, input hazd_ctl_e c_mem,
                                            input hazd_ctl_e c_wb);
        stage_ctl_t c;
        c.if_ctl  = c_if;
        c.id_ctl  = c_id;
        c.ex_ctl  = c_ex;
        c.mem_ctl = c_mem;
        c.wb_ctl  = c_wb;
        return c;
    endfunction

    // stall rule worked out source by source
    function automatic bit ref_data_hazard(input reg_idx_t idx, input stage_status_t st,
                                           input bit br, input bit sto);
        logic [`HAZD_REG_IDX_WIDTH-1:0] src [2];
        bit ex_hit;
        bit mem_hit;
        int k;
        src[0]  = idx.id_src1;
        src[1]  = idx.id_src2;
        ex_hit  = 1'b0;
        mem_hit = 1'b0;
        for (k = 0; k < 2; k++) begin
            if (src[k] != 0) begin                      // x0 never waits
                if (st.ex_reg_write && !st.ex_no_op && src[k] == idx.ex_dest)
                    ex_hit = 1'b1;
                if (st.mem_reg_write && !st.mem_no_op && src[k] == idx.mem_dest)
                    mem_hit = 1'b1;
            end
        end
        if (sto && idx.id_dest == idx.ex_dest)
            ex_hit = 1'b1;                              // store data still being made in ex
        return (br && (ex_hit || mem_hit)) || (st.ex_mem_read && ex_hit);
    endfunction

    // a stage behind a bubble comes back as a bubble
    function automatic stage_ctl_t apply_bubble_mask(input stage_ctl_t c, input stage_status_t s);
        stage_ctl_t m;
        m = c;
        if (s.if_no_op)
            m.id_ctl = NO_OP;
        if (s.id_no_op)
            m.ex_ctl = NO_OP;
        if (s.ex_no_op)
            m.mem_ctl = NO_OP;
        if (s.mem_no_op)
            m.wb_ctl = NO_OP;
        return m;
    endfunction

    function automatic logic [`HAZD_REG_IDX_WIDTH-1:0] rand_idx();
        logic [31:0]                    r;
        logic [`HAZD_REG_IDX_WIDTH-1:0] v;
        r      = $random(seed);
        v      = '0;
        v[1:0] = r[1:0];                                // x0..x3 only, so indices collide often
        return v;
    endfunction

    task automatic compare_value(input string field, input logic [15:0] expected,
                                 input logic [15:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            test_errs++;
            $display("FAIL %s %s expected %h actual %h", cur_test, field, expected, actual);
        end
    endtask

    task automatic expect_after_edge(input issue_e issue, input stage_ctl_t ctl,
                                     input logic [3:0] flags);
        exp_issue = issue;
        exp_ctl   = ctl;
        exp_flags = flags;
        check_on  = 1'b1;
        @(negedge clk);                                 // compare runs after the rising edge between
    endtask

    task automatic clear_inputs();
        branch_instruction = 1'b0;
        store_instruction  = 1'b0;
        stage_status       = '0;
        reg_idx            = '0;                        // all x0, nothing can conflict
        cpu_pause          = 1'b0;
        input_enable       = 1'b0;
        input_complete     = 1'b0;
        uart_write_enable  = 1'b0;
        uart_complete      = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("%-18s done, %0d mismatches", cur_test, test_errs);
    endtask

    // hold pause from execute until the drain finishes
    task automatic drain_to_pause();
        int k;
        cpu_pause = 1'b1;
        for (k = 0; k < `HAZD_DRAIN_LEN; k++) begin
            expect_after_edge(NONE, CTL_DRAIN, 4'b1000);
        end
        expect_after_edge(PAUSE, CTL_DRAIN, 4'b0000);   // edge DRAIN_LEN+1, pipe empty
    endtask

    always @(posedge clk) begin : compare_outputs
        #(CLK_PERIOD / 10.0);                           // registered outputs settled
        if (check_on) begin
            compare_value("issue_type", exp_issue, issue_type);
            compare_value("stage_ctl", exp_ctl, stage_ctl);
            compare_value("flags", exp_flags, {uart_disable, ignore_pause, pc_reset, ignore_no_op});
        end
    end

    initial begin : watchdog
        #(2.0 * TOTAL_CYCLES * CLK_PERIOD);
        $display("watchdog: run still going after %0d cycles, stopping", 2 * TOTAL_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        reg_idx_t      ri;
        stage_status_t ss;
        logic [31:0]   rnd;
        bit            hz;
        int            hits;
        int            n;
        issue_e        pre_issue;
        stage_ctl_t    pre_ctl;
        seed      = 27300;
        err_cnt   = 0;
        test_errs = 0;
        check_cnt = 0;
        test_cnt  = 0;
        check_on  = 1'b0;
        rst_n     = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES - 1) @(negedge clk);

        begin_test("reset_values");
        expect_after_edge(NONE, CTL_NORMAL, 4'b1000);   // last edge in reset
        rst_n = 1'b1;
        expect_after_edge(NONE, CTL_NORMAL, 4'b1000);   // idle to execute, outputs unchanged
        end_test();

        begin_test("data_hazard");
        hits = 0;
        for (n = 0; n < HAZ_ITERS; n++) begin
            ri.id_src1 = rand_idx();
            ri.id_src2 = rand_idx();
            ri.id_dest = rand_idx();
            ri.ex_dest = rand_idx();
            ri.mem_dest = rand_idx();
            rnd = $random(seed);
            ss  = stage_status_t'(rnd[6:0]);
            reg_idx            = ri;
            stage_status       = ss;
            branch_instruction = rnd[7];
            store_instruction  = rnd[8];
            hz = ref_data_hazard(ri, ss, rnd[7], rnd[8]);
            if (hz) begin
                hits++;
                expect_after_edge(DATA, make_ctl(RETRY, RETRY, NO_OP, NORMAL, NORMAL), 4'b1000);
            end else begin
                expect_after_edge(NONE, CTL_NORMAL, 4'b1000);
            end
            clear_inputs();
            expect_after_edge(NONE, CTL_NORMAL, 4'b1000);
        end
        $display("data_hazard: %0d of %0d sets stalled", hits, HAZ_ITERS);
        end_test();

        begin_test("pause_drain");
        drain_to_pause();
        expect_after_edge(PAUSE, CTL_DRAIN, 4'b0000);   // pause held, stays put
        cpu_pause = 1'b0;
        expect_after_edge(NONE, CTL_NORMAL, 4'b1000);
        expect_after_edge(NONE, CTL_NORMAL, 4'b1000);
        end_test();

        begin_test("uart_rewrite");
        drain_to_pause();
        uart_write_enable = 1'b1;
        expect_after_edge(UART, CTL_DRAIN, 4'b0100);
        uart_write_enable = 1'b0;
        uart_complete     = 1'b1;
        expect_after_edge(PAUSE, CTL_DRAIN, 4'b0010);   // pc_reset pulse
        uart_complete = 1'b0;
        expect_after_edge(PAUSE, CTL_DRAIN, 4'b0000);   // pulse gone after one cycle
        cpu_pause = 1'b0;
        expect_after_edge(NONE, CTL_NORMAL, 4'b1000);
        end_test();

        begin_test("keypad_interrupt");
        ri              = '0;
        ri.id_src1      = 3;
        ri.ex_dest      = 3;                            // branch reads what ex is writing
        ss              = '0;
        ss.if_no_op     = 1'b1;
        ss.mem_no_op    = 1'b1;
        ss.ex_reg_write = 1'b1;
        reg_idx            = ri;
        stage_status       = ss;
        branch_instruction = 1'b1;
        input_enable       = 1'b1;
        if (ref_data_hazard(ri, ss, 1'b1, 1'b0)) begin
            pre_issue = DATA;
            pre_ctl   = make_ctl(RETRY, RETRY, NO_OP, NORMAL, NORMAL);
        end else begin
            pre_issue = NONE;
            pre_ctl   = CTL_NORMAL;
        end
        pre_ctl = apply_bubble_mask(pre_ctl, ss);
        expect_after_edge(KEYPAD, CTL_FROZEN, 4'b1000);
        clear_inputs();
        cpu_pause = 1'b1;
        expect_after_edge(PAUSE, CTL_FROZEN, 4'b0000);
        cpu_pause = 1'b0;
        expect_after_edge(KEYPAD, CTL_FROZEN, 4'b1000);
        input_complete = 1'b1;
        expect_after_edge(pre_issue, pre_ctl, 4'b1001); // snapshot back, stale bubbles ignored
        input_complete = 1'b0;
        expect_after_edge(NONE, CTL_NORMAL, 4'b1000);
        end_test();

        $display("summary: %0d tests, %0d checks, %0d mismatches", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0                    // full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                                     // first rising edge at half a period
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- hdl/data_hazard_detector.sv
`default_nettype none
`timescale 1ns/10ps

`include "hazard_params.svh"

module data_hazard_detector (
    input  pipeline_pkg::reg_idx_t      reg_idx,            // indices from id, ex and mem
    input  pipeline_pkg::stage_status_t stage_status,       // bubble and enable flags
    input  logic                        branch_instruction, // id holds a branch
    input  logic                        store_instruction,  // id holds a store
    output logic                        data_hazard         // stall needed this cycle
);

    localparam logic [`HAZD_REG_IDX_WIDTH-1:0] REG_ZERO = '0; // x0, never a dependency

    logic src1_valid;
    logic src2_valid;
    logic mem_live;
    logic ex_live;
    logic mem_conflict;
    logic ex_conflict;
    logic store_conflict;

    assign src1_valid = (reg_idx.id_src1 != REG_ZERO);     // source 1 really read
    assign src2_valid = (reg_idx.id_src2 != REG_ZERO);     // source 2 really read

    // a stage only matters if it writes back and is not a bubble
    assign mem_live = stage_status.mem_reg_write & ~stage_status.mem_no_op;
    assign ex_live  = stage_status.ex_reg_write  & ~stage_status.ex_no_op;

    assign mem_conflict = mem_live &
                          ((src1_valid & (reg_idx.id_src1 == reg_idx.mem_dest)) |
                           (src2_valid & (reg_idx.id_src2 == reg_idx.mem_dest)));

    // store data register is read late, compared against ex only
    assign store_conflict = store_instruction & (reg_idx.id_dest == reg_idx.ex_dest);

    assign ex_conflict = (ex_live &
                          ((src1_valid & (reg_idx.id_src1 == reg_idx.ex_dest)) |
                           (src2_valid & (reg_idx.id_src2 == reg_idx.ex_dest)))) |
                         store_conflict;

    // branches resolve in id so both later stages count
    // an alu op only waits on a load still in ex
    assign data_hazard = (branch_instruction & (ex_conflict | mem_conflict)) |
                         (stage_status.ex_mem_read & ex_conflict);

endmodule

`default_nettype wire

//--- hdl/hazard_params.svh
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// register file index width
// 32 registers, x0 is never a real dependency
`define HAZD_REG_IDX_WIDTH 5

// IF, ID, EX, MEM, WB
`define HAZD_STAGE_CNT 5

// bubbles pumped in before a pause takes hold
// one per stage so the whole pipe is empty
`define HAZD_DRAIN_LEN `HAZD_STAGE_CNT

`endif

//--- hdl/hazard_unit.sv
`default_nettype none
`timescale 1ns/10ps

module hazard_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        branch_instruction, // id holds a branch
    input  logic                        store_instruction,  // id holds a store
    input  pipeline_pkg::stage_status_t stage_status,       // from the stage registers
    input  pipeline_pkg::reg_idx_t      reg_idx,            // from decode and later stages
    input  logic                        cpu_pause,          // from the input unit
    input  logic                        input_enable,       // from data memory
    input  logic                        input_complete,     // from the input unit
    input  logic                        uart_write_enable,  // from the uart unit
    input  logic                        uart_complete,      // from the uart unit
    output pipeline_pkg::stage_ctl_t    stage_ctl,          // to each stage register
    output issue_pkg::issue_e           issue_type,         // to the display
    output logic                        uart_disable,       // to uart and both memories
    output logic                        ignore_pause,       // to the input unit
    output logic                        pc_reset,           // to instruction memory
    output logic                        ignore_no_op        // to each stage register
);

    import issue_pkg::*;

    logic      data_hazard;
    logic      snap_take;
    snapshot_t snap_value;
    snapshot_t snap_held;

    data_hazard_detector u_detector (
        .reg_idx            (reg_idx),
        .stage_status       (stage_status),
        .branch_instruction (branch_instruction),
        .store_instruction  (store_instruction),
        .data_hazard        (data_hazard)
    );

    interrupt_snapshot u_snapshot (
        .clk          (clk),
        .rst_n        (rst_n),
        .snap_take    (snap_take),
        .snap_value   (snap_value),
        .stage_status (stage_status),
        .snap_held    (snap_held)
    );

    issue_controller u_controller (
        .clk               (clk),
        .rst_n             (rst_n),
        .data_hazard       (data_hazard),
        .cpu_pause         (cpu_pause),
        .input_enable      (input_enable),
        .input_complete    (input_complete),
        .uart_write_enable (uart_write_enable),
        .uart_complete     (uart_complete),
        .snap_held         (snap_held),
        .snap_take         (snap_take),
        .snap_value        (snap_value),
        .stage_ctl         (stage_ctl),
        .issue_type        (issue_type),
        .uart_disable      (uart_disable),
        .ignore_pause      (ignore_pause),
        .pc_reset          (pc_reset),
        .ignore_no_op      (ignore_no_op)
    );

endmodule

`default_nettype wire

//--- hdl/interrupt_snapshot.sv
`default_nettype none
`timescale 1ns/10ps

module interrupt_snapshot (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        snap_take,      // pulse on keypad entry
    input  issue_pkg::snapshot_t        snap_value,     // state the cycle would have had
    input  pipeline_pkg::stage_status_t stage_status,   // bubble flags at entry
    output issue_pkg::snapshot_t        snap_held       // saved state for restore
);

    import pipeline_pkg::*;
    import issue_pkg::*;

    snapshot_t snap_masked;

    // a stage fed by a bubble must come back as a bubble
    always_comb begin
        snap_masked = snap_value;                           // if_ctl and issue/state pass as is
        if (stage_status.if_no_op) begin
            snap_masked.ctl.id_ctl = NO_OP;
        end
        if (stage_status.id_no_op) begin
            snap_masked.ctl.ex_ctl = NO_OP;
        end
        if (stage_status.ex_no_op) begin
            snap_masked.ctl.mem_ctl = NO_OP;
        end
        if (stage_status.mem_no_op) begin
            snap_masked.ctl.wb_ctl = NO_OP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snap_held <= '0;                                // idle, none, all normal
        end else if (snap_take) begin
            snap_held <= snap_masked;                       // kept until the next interrupt
        end
    end

endmodule

`default_nettype wire

//--- hdl/issue_controller.sv
`default_nettype none
`timescale 1ns/10ps

`include "hazard_params.svh"

module issue_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     data_hazard,       // from the detector
    input  logic                     cpu_pause,         // user holds pause
    input  logic                     input_enable,      // keypad input requested
    input  logic                     input_complete,    // user pressed enter
    input  logic                     uart_write_enable, // uart is writing memory
    input  logic                     uart_complete,     // uart rewrite done
    input  issue_pkg::snapshot_t     snap_held,         // saved state to restore
    output logic                     snap_take,         // capture pulse
    output issue_pkg::snapshot_t     snap_value,        // state without the interrupt
    output pipeline_pkg::stage_ctl_t stage_ctl,         // per-stage codes
    output issue_pkg::issue_e        issue_type,        // to the display
    output logic                     uart_disable,      // uart held in reset
    output logic                     ignore_pause,      // resume blocked during uart
    output logic                     pc_reset,          // one-cycle pc clear
    output logic                     ignore_no_op       // stages ignore stale bubbles
);

    import pipeline_pkg::*;
    import issue_pkg::*;

    localparam int CNT_W = $clog2(`HAZD_DRAIN_LEN + 1);
    localparam logic [CNT_W-1:0] DRAIN_LAST = CNT_W'(`HAZD_DRAIN_LEN);

    localparam stage_ctl_t CTL_ALL_NORMAL = stage_ctl_t'({`HAZD_STAGE_CNT{NORMAL}});
    localparam stage_ctl_t CTL_ALL_NO_OP  = stage_ctl_t'({`HAZD_STAGE_CNT{NO_OP}});

    cpu_state_e       cpu_state;
    logic [CNT_W-1:0] drain_cnt;                            // bubbles pumped so far

    cpu_state_e       nxt_state;
    issue_e           nxt_issue;
    stage_ctl_t       nxt_ctl;
    logic [CNT_W-1:0] nxt_cnt;
    logic             nxt_uart_disable;
    logic             nxt_ignore_pause;
    logic             nxt_pc_reset;
    logic             nxt_ignore_no_op;
    logic             in_pipe;                              // pipeline is moving or stalled on data

    assign in_pipe = (cpu_state == EXECUTE) ||
                     ((cpu_state == HAZARD) && (issue_type == DATA));

    always_comb begin
        nxt_state        = cpu_state;                       // hold by default
        nxt_issue        = issue_type;
        nxt_ctl          = stage_ctl;
        nxt_cnt          = drain_cnt;
        nxt_uart_disable = uart_disable;
        nxt_ignore_pause = ignore_pause;
        nxt_pc_reset     = pc_reset;
        nxt_ignore_no_op = ignore_no_op;
        snap_take        = 1'b0;

        // first cycle back from the keypad drops the restored codes
        if (in_pipe && ignore_no_op) begin
            nxt_ignore_no_op = 1'b0;
            nxt_ctl          = CTL_ALL_NORMAL;
        end

        case (cpu_state)
            EXECUTE: begin
                if (data_hazard) begin                      // data stall wins over pause
                    nxt_issue      = DATA;
                    nxt_state      = HAZARD;
                    nxt_ctl.if_ctl = RETRY;                 // refetch same pc
                    nxt_ctl.id_ctl = RETRY;                 // keep dependent instr
                    nxt_ctl.ex_ctl = NO_OP;                 // bubble into ex
                end else if (cpu_pause) begin
                    nxt_ctl.if_ctl = NO_OP;                 // drain with bubbles
                    if (drain_cnt == DRAIN_LAST) begin      // pipe is empty now
                        nxt_cnt          = '0;
                        nxt_issue        = PAUSE;
                        nxt_state        = HAZARD;
                        nxt_uart_disable = 1'b0;            // uart may rewrite
                    end else begin
                        nxt_cnt = drain_cnt + 1'b1;
                    end
                end else begin
                    nxt_cnt        = '0;                    // pause dropped mid drain
                    nxt_ctl.if_ctl = NORMAL;
                end
            end
            HAZARD, INTERRUPT: begin
                case (issue_type)
                    DATA: begin
                        if (!data_hazard) begin             // dependency resolved
                            nxt_issue      = NONE;
                            nxt_state      = EXECUTE;
                            nxt_ctl.if_ctl = NORMAL;
                            nxt_ctl.id_ctl = NORMAL;
                            nxt_ctl.ex_ctl = NORMAL;
                            if (cpu_pause) begin
                                nxt_ctl.if_ctl = NO_OP;     // keep draining
                                nxt_cnt        = drain_cnt + 1'b1;
                            end else begin
                                nxt_cnt = '0;
                            end
                        end
                    end
                    PAUSE: begin
                        nxt_pc_reset = 1'b0;                // end of the pc_reset pulse
                        if (uart_write_enable) begin
                            nxt_issue        = UART;
                            nxt_ignore_pause = 1'b1;        // no resume mid rewrite
                        end else if (!cpu_pause) begin
                            nxt_uart_disable = 1'b1;
                            if (cpu_state == HAZARD) begin
                                nxt_issue      = NONE;
                                nxt_state      = EXECUTE;
                                nxt_ctl.if_ctl = NORMAL;    // fetch resumes
                            end else begin
                                nxt_issue = KEYPAD;         // still waiting on enter
                            end
                        end
                    end
                    UART: begin
                        if (uart_complete) begin
                            nxt_issue        = PAUSE;
                            nxt_ignore_pause = 1'b0;
                            nxt_pc_reset     = 1'b1;        // new program starts at 0
                        end
                    end
                    KEYPAD: begin
                        if (input_complete) begin
                            nxt_issue        = snap_held.issue;
                            nxt_state        = snap_held.state;
                            nxt_ctl          = snap_held.ctl;
                            nxt_ignore_no_op = 1'b1;        // trust the snapshot only
                        end else if (cpu_pause) begin
                            nxt_issue        = PAUSE;
                            nxt_uart_disable = 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            default: begin
                nxt_state = EXECUTE;                        // idle lasts one cycle
            end
        endcase

        // what the cycle would have done without the interrupt
        snap_value.issue = nxt_issue;
        snap_value.state = nxt_state;
        snap_value.ctl   = nxt_ctl;

        if (in_pipe && input_enable) begin                  // freeze everything for input
            snap_take = 1'b1;
            nxt_issue = KEYPAD;
            nxt_state = INTERRUPT;
            nxt_ctl   = CTL_ALL_NO_OP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_state    <= IDLE;
            issue_type   <= NONE;
            stage_ctl    <= CTL_ALL_NORMAL;
            drain_cnt    <= '0;
            uart_disable <= 1'b1;                           // uart off while running
            ignore_pause <= 1'b0;
            pc_reset     <= 1'b0;
            ignore_no_op <= 1'b0;
        end else begin
            cpu_state    <= nxt_state;
            issue_type   <= nxt_issue;
            stage_ctl    <= nxt_ctl;
            drain_cnt    <= nxt_cnt;
            uart_disable <= nxt_uart_disable;
            ignore_pause <= nxt_ignore_pause;
            pc_reset     <= nxt_pc_reset;
            ignore_no_op <= nxt_ignore_no_op;
        end
    end

endmodule

`default_nettype wire

//--- hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // what the cpu as a whole is doing
    typedef enum logic [1:0] {
        IDLE      = 2'b00,                              // one cycle after reset for fetch
        EXECUTE   = 2'b01,                              // normal flow
        HAZARD    = 2'b10,                              // data stall or user pause
        INTERRUPT = 2'b11                               // waiting on keypad input
    } cpu_state_e;

    // reason for the current hold, also shown on the display
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        DATA   = 3'd1,                                  // load-use or branch dependency
        PAUSE  = 3'd2,                                  // user pause, pipe drained
        UART   = 3'd3,                                  // uart rewrite in progress
        KEYPAD = 3'd4                                   // keypad input pending
    } issue_e;

    // control state saved on keypad entry, put back on enter
    typedef struct packed {
        issue_e                 issue;
        cpu_state_e             state;
        pipeline_pkg::stage_ctl_t ctl;
    } snapshot_t;

endpackage

`default_nettype wire

//--- hdl/pipeline_pkg.sv
`default_nettype none

`include "hazard_params.svh"

package pipeline_pkg;

    // control code sent to each stage register
    typedef enum logic [1:0] {
        NORMAL = 2'b00,                                 // latch as usual
        RETRY  = 2'b01,                                 // hold current contents
        NO_OP  = 2'b10                                  // load a bubble
    } hazd_ctl_e;

    // one code per stage register, if first
    typedef struct packed {
        hazd_ctl_e if_ctl;
        hazd_ctl_e id_ctl;
        hazd_ctl_e ex_ctl;
        hazd_ctl_e mem_ctl;
        hazd_ctl_e wb_ctl;
    } stage_ctl_t;

    // status flags coming back from the stage registers
    typedef struct packed {
        logic if_no_op;                                 // if stage holds a bubble
        logic id_no_op;                                 // id stage holds a bubble
        logic ex_no_op;                                 // ex stage holds a bubble
        logic mem_no_op;                                // mem stage holds a bubble
        logic ex_mem_read;                              // ex instr is a load
        logic ex_reg_write;                             // ex instr writes the reg file
        logic mem_reg_write;                            // mem instr writes the reg file
    } stage_status_t;

    // register indices seen by the hazard check
    typedef struct packed {
        logic [`HAZD_REG_IDX_WIDTH-1:0] id_src1;        // first source in id
        logic [`HAZD_REG_IDX_WIDTH-1:0] id_src2;        // second source in id
        logic [`HAZD_REG_IDX_WIDTH-1:0] id_dest;        // dest, or data reg of a store
        logic [`HAZD_REG_IDX_WIDTH-1:0] ex_dest;        // dest of the ex instr
        logic [`HAZD_REG_IDX_WIDTH-1:0] mem_dest;       // dest of the mem instr
    } reg_idx_t;

endpackage

`default_nettype wire
